//--- rsa_b_pkg.sv
package rsa_b_pkg;

  localparam int rsa_dw    = 32;
  localparam int lanes     = 4;
  localparam int jac_words = 16;

  typedef logic signed [rsa_dw-1:0] data_t;

  // lane0 sits in the low bits of a row
  typedef struct packed {
    data_t lane3;
    data_t lane2;
    data_t lane1;
    data_t lane0;
  } b_row_t;

  typedef enum logic [2:0] {
    mode_idle   = 3'd0,
    mode_tb     = 3'd1,  // copy from temp buffer
    mode_nl_prd = 3'd5,
    mode_nl_new = 3'd6,
    mode_nl_upd = 3'd7
  } load_mode_t;

  // field order is the register order from reg_jac_base upward
  typedef struct packed {
    data_t fxi_13;
    data_t fxi_23;
    data_t gxi_13;
    data_t gxi_23;
    data_t gz_11;
    data_t gz_12;
    data_t gz_21;
    data_t gz_22;
    data_t hz_11;
    data_t hz_12;
    data_t hz_21;
    data_t hz_22;
    data_t hxi_11;
    data_t hxi_12;
    data_t hxi_21;
    data_t hxi_22;
  } jacobian_t;

  typedef struct packed {
    load_mode_t mode;
    logic [7:0] len;  // rows, mode_tb only
  } load_cmd_t;

  typedef struct packed {
    logic       en;
    logic [7:0] addr;
    b_row_t     row;
  } b_wr_t;

  localparam logic [7:0] reg_ctrl     = 8'h00;
  localparam logic [7:0] reg_status   = 8'h04;
  localparam logic [7:0] reg_jac_base = 8'h40;

  localparam int prd_steps = 3;
  localparam int new_steps = 6;
  localparam int upd_steps = 5;

  function automatic logic mode_legal(load_mode_t m);
    return m inside {mode_idle, mode_tb, mode_nl_prd, mode_nl_new, mode_nl_upd};
  endfunction

endpackage

//--- jacobian_regs.sv
`timescale 1ns/1ps

module jacobian_regs (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  logic [7:0]            awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [31:0]           wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [7:0]            araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  input  logic                  busy,
  input  logic                  done_set,
  output logic                  cmd_valid,
  output rsa_b_pkg::load_cmd_t  cmd,
  output rsa_b_pkg::jacobian_t  jac
);
  import rsa_b_pkg::*;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  data_t [0:jac_words-1] jac_q;  // word 0 lands on fxi_13
  load_mode_t            ctrl_mode;
  logic [7:0]            ctrl_len;
  logic                  done_q;

  logic        wr_go;
  logic        wr_hs;
  logic        rd_hs;
  logic [7:0]  wr_off;
  logic [7:0]  rd_off;
  logic        wr_ctrl;
  logic        wr_jac;
  logic        rd_jac;
  logic        blocked;
  logic        start_req;
  logic        mode_bad;
  logic        wr_err;
  logic [31:0] ctrl_word;
  logic [31:0] ctrl_new;
  load_mode_t  new_mode;
  logic [31:0] rd_word;

  assign wr_go   = awvalid && wvalid && !awready && !bvalid;
  assign wr_hs   = awvalid && awready && wvalid && wready;
  assign rd_hs   = arvalid && arready;
  assign wr_off  = awaddr - reg_jac_base;
  assign rd_off  = araddr - reg_jac_base;
  assign wr_ctrl = (awaddr == reg_ctrl);
  assign wr_jac  = (awaddr >= reg_jac_base) && (wr_off < 8'(4 * jac_words));
  assign rd_jac  = (araddr >= reg_jac_base) && (rd_off < 8'(4 * jac_words));
  assign blocked = busy || cmd_valid;  // command already on its way counts as busy

  assign ctrl_word = {16'd0, ctrl_len, 4'd0, ctrl_mode, 1'b0};

  always_comb begin
    ctrl_new = ctrl_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        ctrl_new[8*b +: 8] = wdata[8*b +: 8];
      end
    end
  end

  assign new_mode  = load_mode_t'(ctrl_new[3:1]);
  assign start_req = wr_ctrl && ctrl_new[0];
  assign mode_bad  = start_req && (!mode_legal(new_mode) || new_mode == mode_idle);
  assign wr_err    = (blocked && (wr_ctrl || wr_jac)) || mode_bad;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_go;  // both ready lines pulse together
      wready  <= wr_go;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= wr_err ? resp_slverr : resp_okay;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      jac_q     <= '0;
      ctrl_mode <= mode_idle;
      ctrl_len  <= '0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= wr_hs && start_req && !wr_err;
      if (wr_hs && !wr_err && wr_ctrl) begin
        ctrl_mode <= new_mode;
        ctrl_len  <= ctrl_new[15:8];
      end
      if (wr_hs && !wr_err && wr_jac) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            jac_q[wr_off[5:2]][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign cmd = '{mode: ctrl_mode, len: ctrl_len};
  assign jac = jacobian_t'(jac_q);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      done_q <= 1'b0;
    end else if (done_set) begin
      done_q <= 1'b1;
    end else if (rd_hs && araddr == reg_status) begin
      done_q <= 1'b0;  // read to clear
    end
  end

  always_comb begin
    rd_word = '0;  // unmapped offsets read zero
    if (araddr == reg_ctrl) begin
      rd_word = ctrl_word;
    end else if (araddr == reg_status) begin
      rd_word = {30'd0, done_q, busy};
    end else if (rd_jac) begin
      rd_word = jac_q[rd_off[5:2]];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (rd_hs) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (rvalid) begin
      if (rready) begin
        rvalid  <= 1'b0;
        arready <= 1'b1;
      end
    end else begin
      arready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= rd_word;
    end
  end

  assign rresp = resp_okay;

  // each response belongs to the one address taken before it
  a_no_aw_during_b: assert property (@(posedge clk) disable iff (sys_rst)
    awready |-> !bvalid);
  a_no_ar_during_r: assert property (@(posedge clk) disable iff (sys_rst)
    arready |-> !rvalid);

endmodule

//--- seq_counter.sv
`timescale 1ns/1ps

module seq_counter #(
  parameter int seq_cnt_dw = 10
) (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  logic                  cnt_clr,
  input  logic                  cnt_en,
  output logic [seq_cnt_dw-1:0] step
);

  // clear wins over enable
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      step <= '0;
    end else if (cnt_clr) begin
      step <= '0;
    end else if (cnt_en) begin
      step <= step + 1'b1;
    end
  end

  // the sequencer stops well before the counter could wrap
  a_no_wrap: assert property (@(posedge clk) disable iff (sys_rst)
    cnt_en && !cnt_clr |-> step != '1);

endmodule

//--- b_load_fsm.sv
`timescale 1ns/1ps

module b_load_fsm #(
  parameter int seq_cnt_dw  = 10,
  parameter int cache_depth = 256
) (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  logic                   cmd_valid,
  input  rsa_b_pkg::load_cmd_t   cmd,
  input  logic [seq_cnt_dw-1:0]  step,
  output logic                   cnt_clr,
  output logic                   cnt_en,
  output rsa_b_pkg::load_mode_t  mode,
  output logic [7:0]             tb_rd_addr,
  output rsa_b_pkg::b_wr_t       cache_wr,
  output logic                   busy,
  output logic                   done_set
);
  import rsa_b_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain
  } state_t;

  state_t                state;
  load_mode_t            mode_q;
  logic [seq_cnt_dw-1:0] limit_q;
  logic [seq_cnt_dw-1:0] limit_d;
  logic                  wr_en_q;
  logic [7:0]            wr_addr_q;
  logic [7:0]            step_addr;

  always_comb begin
    case (cmd.mode)
      mode_nl_prd: limit_d = seq_cnt_dw'(prd_steps);
      mode_nl_new: limit_d = seq_cnt_dw'(new_steps);
      mode_nl_upd: limit_d = seq_cnt_dw'(upd_steps);
      mode_tb: begin
        if (int'(cmd.len) > cache_depth) begin
          limit_d = seq_cnt_dw'(cache_depth);  // never run past the cache
        end else begin
          limit_d = seq_cnt_dw'(cmd.len);
        end
      end
      default: limit_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state   <= st_idle;
      mode_q  <= mode_idle;
      limit_q <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            mode_q  <= cmd.mode;
            limit_q <= limit_d;
            state   <= (limit_d == '0) ? st_drain : st_run;  // empty copy just reports done
          end
        end
        st_run: begin
          if (step >= limit_q) begin
            state <= st_drain;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy     = (state != st_idle);
  assign done_set = (state == st_drain);
  assign cnt_clr  = (state == st_drain) || (state == st_idle && !cmd_valid);
  assign cnt_en   = (state == st_idle) ? (cmd_valid && limit_d != '0)
                                       : (state == st_run && step < limit_q);
  assign mode     = (state == st_run) ? mode_q : mode_idle;

  assign step_addr  = 8'(step - 1'b1);  // step k lands at row k-1
  assign tb_rd_addr = step_addr;

  // one cycle behind the step, in line with the mapper register
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= (state == st_run);
    end
  end

  always_ff @(posedge clk) begin
    wr_addr_q <= step_addr;
  end

  assign cache_wr = '{en: wr_en_q, addr: wr_addr_q, row: '0};

  a_no_cmd_busy: assert property (@(posedge clk) disable iff (sys_rst)
    cmd_valid |-> !busy);
  a_step_limit: assert property (@(posedge clk) disable iff (sys_rst)
    state == st_run |-> step != '0 && step <= limit_q);

endmodule

//--- b_cache_din_map.sv
`timescale 1ns/1ps

module b_cache_din_map #(
  parameter int seq_cnt_dw = 10
) (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  rsa_b_pkg::load_mode_t  mode,
  input  logic [seq_cnt_dw-1:0]  step,
  input  rsa_b_pkg::b_row_t      tb_dout,
  input  rsa_b_pkg::jacobian_t   jac,
  output rsa_b_pkg::b_row_t      din
);
  import rsa_b_pkg::*;

  localparam data_t one     = data_t'(1);
  localparam data_t neg_one = data_t'(-1);

  data_t [lanes-1:0] nl;  // nl[0] is lane0
  b_row_t            row_d;

  always_comb begin
    nl = '0;
    case (mode)
      mode_nl_prd: begin
        case (step)
          1: nl[0] = one;
          2: nl[1] = one;
          3: begin
            nl[0] = jac.fxi_13;
            nl[1] = jac.fxi_23;
            nl[2] = one;
          end
          default: nl = '0;
        endcase
      end
      mode_nl_new: begin
        case (step)  // step 2 is an all zero row
          1: nl[0] = one;
          3: begin
            nl[0] = jac.gxi_13;
            nl[1] = one;
          end
          4: begin
            nl[0] = jac.gz_11;
            nl[1] = jac.gxi_13;
          end
          5: begin
            nl[0] = jac.gz_12;
            nl[1] = jac.gz_21;
          end
          6: nl[1] = jac.gz_22;
          default: nl = '0;
        endcase
      end
      mode_nl_upd: begin
        case (step)
          1: nl[0] = jac.hxi_11;
          2: begin
            nl[0] = jac.hxi_12;
            nl[1] = jac.hxi_21;
          end
          3: nl[1] = jac.hxi_22;
          4: begin
            nl[0] = jac.hz_11;
            nl[1] = neg_one;
          end
          5: begin
            nl[0] = jac.hz_12;
            nl[1] = jac.hz_21;
          end
          default: nl = '0;
        endcase
      end
      default: nl = '0;
    endcase
  end

  assign row_d = (mode == mode_tb) ? tb_dout : b_row_t'(nl);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      din <= '0;
    end else begin
      din <= row_d;
    end
  end

  a_mode_legal: assert property (@(posedge clk) disable iff (sys_rst)
    mode_legal(mode));

endmodule

//--- b_cache.sv
`timescale 1ns/1ps

module b_cache #(
  parameter int cache_depth = 256
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  rsa_b_pkg::b_wr_t   wr,
  input  logic [7:0]         rd_addr,
  output rsa_b_pkg::b_row_t  rd_data
);
  import rsa_b_pkg::*;

  b_row_t mem [cache_depth];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.row;
    end
  end

  // registered read, one cycle after rd_addr
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

  a_wr_in_range: assert property (@(posedge clk) disable iff (sys_rst)
    wr.en |-> int'(wr.addr) < cache_depth);

endmodule

//--- b_loader_top.sv
`timescale 1ns/1ps

module b_loader_top #(
  parameter int seq_cnt_dw  = 10,
  parameter int cache_depth = 256
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic [7:0]         awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [31:0]        wdata,
  input  logic [3:0]         wstrb,
  input  logic               wvalid,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [7:0]         araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [31:0]        rdata,
  output logic [1:0]         rresp,
  output logic               rvalid,
  input  logic               rready,
  output logic [7:0]         tb_rd_addr,
  input  rsa_b_pkg::b_row_t  tb_dout,
  input  logic [7:0]         rd_addr,
  output rsa_b_pkg::b_row_t  rd_data,
  output logic               irq_done
);
  import rsa_b_pkg::*;

  logic                  busy;
  logic                  done_set;
  logic                  cmd_valid;
  logic                  cnt_clr;
  logic                  cnt_en;
  load_cmd_t             cmd;
  jacobian_t             jac;
  load_mode_t            mode;
  logic [seq_cnt_dw-1:0] step;
  b_row_t                din;
  b_wr_t                 fsm_wr;
  b_wr_t                 cache_wr;

  assign cache_wr = '{en: fsm_wr.en, addr: fsm_wr.addr, row: din};  // mapper row joins the strobe
  assign irq_done = done_set;

  jacobian_regs jacobian_regs_inst (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .busy      (busy),
    .done_set  (done_set),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .jac       (jac)
  );

  b_load_fsm #(
    .seq_cnt_dw  (seq_cnt_dw),
    .cache_depth (cache_depth)
  ) b_load_fsm_inst (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .step       (step),
    .cnt_clr    (cnt_clr),
    .cnt_en     (cnt_en),
    .mode       (mode),
    .tb_rd_addr (tb_rd_addr),
    .cache_wr   (fsm_wr),
    .busy       (busy),
    .done_set   (done_set)
  );

  seq_counter #(
    .seq_cnt_dw (seq_cnt_dw)
  ) seq_counter_inst (
    .clk     (clk),
    .sys_rst (sys_rst),
    .cnt_clr (cnt_clr),
    .cnt_en  (cnt_en),
    .step    (step)
  );

  b_cache_din_map #(
    .seq_cnt_dw (seq_cnt_dw)
  ) b_cache_din_map_inst (
    .clk     (clk),
    .sys_rst (sys_rst),
    .mode    (mode),
    .step    (step),
    .tb_dout (tb_dout),
    .jac     (jac),
    .din     (din)
  );

  b_cache #(
    .cache_depth (cache_depth)
  ) b_cache_inst (
    .clk     (clk),
    .sys_rst (sys_rst),
    .wr      (cache_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- tb_b_loader.sv
`timescale 1ns/1ps

module tb_b_loader;
  import rsa_b_pkg::*;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;
  localparam int         axi_cost    = 6;  // cycles per AXI transaction, generous

  typedef struct packed {
    logic [2:0] mode;
    logic [7:0] len;
    logic       slverr;
    logic       busy_wr;  // also try register writes while the load runs
  } test_t;

  localparam int n_tests = 8;
  localparam test_t tests [n_tests] = '{
    '{mode: 3'(mode_nl_prd), len: 8'd0,  slverr: 1'b0, busy_wr: 1'b0},
    '{mode: 3'(mode_nl_new), len: 8'd0,  slverr: 1'b0, busy_wr: 1'b0},
    '{mode: 3'(mode_nl_upd), len: 8'd0,  slverr: 1'b0, busy_wr: 1'b0},
    '{mode: 3'(mode_tb),     len: 8'd1,  slverr: 1'b0, busy_wr: 1'b0},
    '{mode: 3'(mode_tb),     len: 8'd7,  slverr: 1'b0, busy_wr: 1'b0},
    '{mode: 3'(mode_tb),     len: 8'd40, slverr: 1'b0, busy_wr: 1'b0},
    '{mode: 3'(mode_nl_new), len: 8'd0,  slverr: 1'b0, busy_wr: 1'b1},
    '{mode: 3'd3,            len: 8'd0,  slverr: 1'b1, busy_wr: 1'b0}
  };
  string labels [n_tests] = '{"nl_prd", "nl_new", "nl_upd", "tb_len1", "tb_len7",
                              "tb_len40", "write_while_busy", "illegal_mode"};

  logic        clk;
  logic        sys_rst;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [7:0]  tb_rd_addr;
  b_row_t      tb_dout;
  logic [7:0]  rd_addr;
  b_row_t      rd_data;
  logic        irq_done;

  b_row_t    tbuf [256];       // temp buffer model
  b_row_t    exp_cache [256];  // expected cache contents
  jacobian_t jm;
  integer    seed;
  int        err_count = 0;
  int        irq_count = 0;
  int        cycles = 0;
  int        cycle_limit;
  int        tests_ok = 0;
  int        tests_bad = 0;

  assign tb_dout = tbuf[tb_rd_addr];

  b_loader_top #(
    .seq_cnt_dw  (10),
    .cache_depth (256)
  ) b_loader_top_inst (
    .clk(clk), .sys_rst(sys_rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .tb_rd_addr(tb_rd_addr), .tb_dout(tb_dout),
    .rd_addr(rd_addr), .rd_data(rd_data), .irq_done(irq_done)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (irq_done) begin
      irq_count <= irq_count + 1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic int steps_of(test_t e);
    if (e.mode == mode_nl_prd) return prd_steps;
    if (e.mode == mode_nl_new) return new_steps;
    if (e.mode == mode_nl_upd) return upd_steps;
    if (e.mode == mode_tb) return int'(e.len);
    return 8;  // illegal start, cache rows checked instead
  endfunction

  function automatic int cycle_budget();
    int total;
    total = 20;  // reset and the first status read
    for (int t = 0; t < n_tests; t++) begin
      total += 2 * steps_of(tests[t]) + 24 * axi_cost;
    end
    return 2 * total;
  endfunction

  // expected row for one step, from the per-mode step tables
  function automatic b_row_t ref_row(logic [2:0] m, int k, jacobian_t j, b_row_t tb_row);
    b_row_t r;
    r = '0;
    case (load_mode_t'(m))
      mode_tb: r = tb_row;
      mode_nl_prd: begin
        if (k == 1) begin
          r.lane0 = 1;
        end else if (k == 2) begin
          r.lane1 = 1;
        end else if (k == 3) begin
          r.lane0 = j.fxi_13;
          r.lane1 = j.fxi_23;
          r.lane2 = 1;
        end
      end
      mode_nl_new: begin
        if (k == 1) r.lane0 = 1;
        if (k == 3) r.lane0 = j.gxi_13;
        if (k == 3) r.lane1 = 1;
        if (k == 4) r.lane0 = j.gz_11;
        if (k == 4) r.lane1 = j.gxi_13;
        if (k == 5) r.lane0 = j.gz_12;
        if (k == 5) r.lane1 = j.gz_21;
        if (k == 6) r.lane1 = j.gz_22;
      end
      mode_nl_upd: begin
        if (k == 1) r.lane0 = j.hxi_11;
        if (k == 2) r.lane0 = j.hxi_12;
        if (k == 2) r.lane1 = j.hxi_21;
        if (k == 3) r.lane1 = j.hxi_22;
        if (k == 4) r.lane0 = j.hz_11;
        if (k == 4) r.lane1 = -1;
        if (k == 5) r.lane0 = j.hz_12;
        if (k == 5) r.lane1 = j.hz_21;
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic check_row(input string name, input b_row_t exp, input b_row_t act);
    if (act !== exp) begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      err_count++;
    end
  endtask

  // inputs change 5 ns after the rising edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    logic hs;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    hs      = 1'b0;
    while (!hs) begin
      hs = awready;  // ready seen now holds at the coming edge
      next_cycle();
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      next_cycle();
    end
    resp = bresp;
    next_cycle();
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    logic hs;
    araddr  = addr;
    arvalid = 1'b1;
    hs      = 1'b0;
    while (!hs) begin
      hs = arready;
      next_cycle();
    end
    arvalid = 1'b0;
    while (!rvalid) begin
      next_cycle();
    end
    data = rdata;
    check_resp("rresp", resp_okay, rresp);
    next_cycle();
  endtask

  task automatic read_row(input int addr, output b_row_t row);
    rd_addr = 8'(addr);
    next_cycle();
    row = rd_data;
  endtask

  task automatic run_test(input int t);
    test_t       e;
    int          n;
    int          irq_before;
    int          errs_before;
    logic [1:0]  resp;
    logic [31:0] word;
    logic [31:0] ctrl;
    b_row_t      row;
    e           = tests[t];
    n           = steps_of(e);
    errs_before = err_count;
    ctrl        = {16'd0, e.len, 4'd0, e.mode, 1'b1};
    if (e.mode == mode_nl_prd || e.mode == mode_nl_new || e.mode == mode_nl_upd) begin
      for (int i = 0; i < jac_words; i++) begin
        jm[511-32*i -: 32] = $random(seed);
        axi_write(reg_jac_base + 8'(4 * i), jm[511-32*i -: 32], resp);
        check_resp("bresp jac", resp_okay, resp);
      end
    end
    irq_before = irq_count;
    axi_write(reg_ctrl, ctrl, resp);
    check_resp("bresp ctrl", e.slverr ? resp_slverr : resp_okay, resp);
    if (e.busy_wr) begin
      axi_write(reg_jac_base + 8'd16, $random(seed), resp);  // gz_11, must not land
      check_resp("bresp jac busy", resp_slverr, resp);
      axi_write(reg_ctrl, ctrl, resp);
      check_resp("bresp ctrl busy", resp_slverr, resp);
    end
    if (!e.slverr) begin
      while (irq_count == irq_before) begin
        next_cycle();
      end
      for (int k = 1; k <= n; k++) begin
        exp_cache[k-1] = ref_row(e.mode, k, jm, tbuf[k-1]);
      end
      for (int r = 0; r < n; r++) begin
        read_row(r, row);
        check_row($sformatf("rd_data[%0d]", r), exp_cache[r], row);
      end
      axi_read(reg_status, word);
      check_word("status", 32'h2, word);  // done set, busy clear
      axi_read(reg_status, word);
      check_word("status", 32'h0, word);
      check_word("irq_done count", 32'(irq_before + 1), 32'(irq_count));
    end else begin
      repeat (4) next_cycle();
      axi_read(reg_status, word);
      check_word("status", 32'h0, word);
      for (int r = 0; r < n; r++) begin
        read_row(r, row);
        check_row($sformatf("rd_data[%0d]", r), exp_cache[r], row);
      end
      check_word("irq_done count", 32'(irq_before), 32'(irq_count));
    end
    if (err_count == errs_before) begin
      tests_ok++;
      $display("test %0d %s: ok", t, labels[t]);
    end else begin
      tests_bad++;
      $display("test %0d %s: FAILED with %0d errors", t, labels[t], err_count - errs_before);
    end
  endtask

  initial begin
    logic [31:0] word;
    sys_rst     = 1'b1;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b1;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b1;
    rd_addr     = '0;
    jm          = '0;
    seed        = 32'h597c383c;
    cycle_limit = cycle_budget();
    for (int a = 0; a < 256; a++) begin
      tbuf[a] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end

    repeat (10) next_cycle();
    check_row("rd_data", '0, rd_data);  // read register still held in reset
    sys_rst = 1'b0;
    axi_read(reg_status, word);
    check_word("status", 32'h0, word);
    if (err_count == 0) begin
      tests_ok++;
      $display("test reset: ok");
    end else begin
      tests_bad++;
      $display("test reset: FAILED with %0d errors", err_count);
    end

    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_ok, tests_bad, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- build.f
rsa_b_pkg.sv
jacobian_regs.sv
seq_counter.sv
b_load_fsm.sv
b_cache_din_map.sv
b_cache.sv
b_loader_top.sv
tb_b_loader.sv
